/* Bender.yml */
package:
  name: ldq_top

export_include_dirs:
  - .

sources:
  - files:
      - ldqTypesPkg.sv
      - ldqMsgPkg.sv
      - ldqEntry.sv
      - ldqArray.sv
      - ldqOccupancy.sv
      - ldqTop.sv
  - target: test
    files:
      - ldqTop_sva.sv
      - ldqTop_tb.sv

/* ldqArray.sv */
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldqArray (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush,
  input  ldqMsgPkg::allocReqT   alloc,
  input  ldqMsgPkg::storeChkT   storeChk,
  input  ldqMsgPkg::retireReqT  retire,
  output ldqMsgPkg::retireRespT retireResp,
  output logic                  allocTaken,
  output logic                  released
);

  localparam int Entries = `LDQ_ENTRIES;

  logic [Entries-1:0] entryValid;
  logic [Entries-1:0] fillVec;
  logic [Entries-1:0] hitVec;
  logic [Entries-1:0] conflVec;

  ldqTypesPkg::entryIdxT pickIdx;
  logic                  anyFree;
  logic                  allocOk;

  ldqMsgPkg::retireRespT respD;

  // priority scan, lowest free entry wins
  always_comb begin
    pickIdx = '0;
    anyFree = 1'b0;
    for (int i = Entries - 1; i >= 0; i--) begin
      if (!entryValid[i]) begin
        pickIdx = ldqTypesPkg::entryIdxT'(i);
        anyFree = 1'b1;
      end
    end
  end

  // a full queue drops the alloc
  assign allocOk = alloc.valid && !flush && anyFree;

  genvar i;
  generate
    for (i = 0; i < Entries; i++) begin : gEntry
      assign fillVec[i] = allocOk && (pickIdx == ldqTypesPkg::entryIdxT'(i));

      ldqEntry u_ldqEntry (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .fill        (fillVec[i]),
        .alloc       (alloc),
        .storeChk    (storeChk),
        .retire      (retire),
        .valid       (entryValid[i]),
        .retireHit   (hitVec[i]),
        .retireConfl (conflVec[i])
      );
    end
  endgenerate

  assign allocTaken = allocOk;

  // entries holding the retired index free at the next edge
  assign released = (hitVec != '0) && !flush;

  // at most one entry matches, so an OR is enough
  always_comb begin
    respD.valid = retire.valid && !flush;
    respD.hit   = |hitVec;
    respD.confl = |conflVec;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      retireResp.valid <= 1'b0;
    end else begin
      retireResp <= respD;
    end
  end

endmodule

/* ldqEntry.sv */
`timescale 1ns/1ps

module ldqEntry (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush,
  input  logic                  fill,
  input  ldqMsgPkg::allocReqT   alloc,
  input  ldqMsgPkg::storeChkT   storeChk,
  input  ldqMsgPkg::retireReqT  retire,
  output logic                  valid,
  output logic                  retireHit,
  output logic                  retireConfl
);

  ldqTypesPkg::lineAddrT addrQ;
  ldqTypesPkg::bankMaskT banksQ;
  ldqTypesPkg::instIdxT  iiQ;
  logic                  conflQ;

  logic chkHit;
  logic fillConfl;

  // same line and at least one shared byte bank
  function automatic logic overlaps(
    input ldqTypesPkg::lineAddrT addrA,
    input ldqTypesPkg::bankMaskT banksA,
    input ldqTypesPkg::lineAddrT addrB,
    input ldqTypesPkg::bankMaskT banksB
  );
    logic sameLine;
    logic sharedBank;
    sameLine   = (addrA == addrB);
    sharedBank = ((banksA & banksB) != '0);
    return sameLine && sharedBank;
  endfunction

  // store check against the stored load
  assign chkHit = valid && storeChk.valid &&
                  overlaps(storeChk.addr, storeChk.banks, addrQ, banksQ);

  // store check against the load arriving this cycle
  assign fillConfl = storeChk.valid &&
                     overlaps(storeChk.addr, storeChk.banks, alloc.addr, alloc.banks);

  assign retireHit = valid && retire.valid && (retire.ii == iiQ);

  // a check landing in the retire cycle still counts
  assign retireConfl = retireHit && (conflQ || chkHit);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid  <= 1'b0;
      conflQ <= 1'b0;
    end else if (flush) begin
      valid  <= 1'b0;
      conflQ <= 1'b0;
    end else if (fill) begin
      valid  <= 1'b1;
      conflQ <= fillConfl;
    end else begin
      if (retireHit) begin
        valid <= 1'b0;
      end
      // sticky until the entry is refilled
      if (chkHit) begin
        conflQ <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      addrQ  <= alloc.addr;
      banksQ <= alloc.banks;
      iiQ    <= alloc.ii;
    end
  end

endmodule

/* ldqMsgPkg.sv */
`include "ldq_defines.svh"

package ldqMsgPkg;

  // new load entering the queue
  typedef struct packed {
    logic                  valid;
    ldqTypesPkg::lineAddrT addr;
    ldqTypesPkg::bankMaskT banks;
    ldqTypesPkg::instIdxT  ii;
  } allocReqT;

  // store address checked against every queued load
  typedef struct packed {
    logic                  valid;
    ldqTypesPkg::lineAddrT addr;
    ldqTypesPkg::bankMaskT banks;
  } storeChkT;

  // load leaving the queue
  typedef struct packed {
    logic                 valid;
    ldqTypesPkg::instIdxT ii;
  } retireReqT;

  // answer to a retire, one cycle later
  typedef struct packed {
    logic valid;
    logic hit;
    logic confl;
  } retireRespT;

endpackage

/* ldqOccupancy.sv */
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldqOccupancy (
  input  logic clk,
  input  logic rst,
  input  logic flush,
  input  logic allocTaken,
  input  logic released,
  output logic doStall
);

  localparam ldqTypesPkg::occCountT StallLevel = `LDQ_STALL_LEVEL;

  ldqTypesPkg::occCountT count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (flush) begin
      count <= '0;
    end else begin
      // fill and free together leave the count alone
      case ({allocTaken, released})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

  // advisory only, nothing inside is held back
  assign doStall = (count >= StallLevel);

endmodule

/* ldqTop.f */
+incdir+.
ldqTypesPkg.sv
ldqMsgPkg.sv
ldqEntry.sv
ldqArray.sv
ldqOccupancy.sv
ldqTop.sv
ldqTop_sva.sv
ldqTop_tb.sv

/* ldqTop.sv */
`timescale 1ns/1ps

module ldqTop (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush,
  input  ldqMsgPkg::allocReqT   alloc,
  input  ldqMsgPkg::storeChkT   storeChk,
  input  ldqMsgPkg::retireReqT  retire,
  output ldqMsgPkg::retireRespT retireResp,
  output logic                  doStall
);

  // fill and free strobes for the counter
  logic allocTaken;
  logic released;

  ldqArray u_ldqArray (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .alloc      (alloc),
    .storeChk   (storeChk),
    .retire     (retire),
    .retireResp (retireResp),
    .allocTaken (allocTaken),
    .released   (released)
  );

  ldqOccupancy u_ldqOccupancy (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .allocTaken (allocTaken),
    .released   (released),
    .doStall    (doStall)
  );

endmodule

/* ldqTop_sva.sv */
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldqTop_sva #(
  parameter bit CheckResp  = 1'b1,
  parameter bit CheckCount = 1'b1
) (
  input logic                  clk,
  input logic                  rst,
  input logic                  flush,
  input logic                  retireValid,
  input logic                  respValid,
  input logic                  allocTaken,
  input logic                  released,
  input ldqTypesPkg::occCountT count
);

  if (CheckResp) begin : gResp
    // response one cycle after an unflushed retire, never otherwise
    respAfterRetire: assert property (
      @(posedge clk) disable iff (rst)
        respValid == $past(retireValid && !flush)
    ) else $error("retire response does not follow the retire strobe by one cycle");
  end

  if (CheckCount) begin : gCount
    // strobes as seen at the counter inputs
    noStrobeInFlush: assert property (
      @(posedge clk) disable iff (rst)
        flush |-> (!allocTaken && !released)
    ) else $error("fill or free strobe raised during a flush");

    countInRange: assert property (
      @(posedge clk) disable iff (rst)
        count <= `LDQ_ENTRIES
    ) else $error("occupancy count above queue depth");
  end

endmodule

bind ldqArray ldqTop_sva #(
  .CheckResp  (1'b1),
  .CheckCount (1'b0)
) u_arraySva (
  .clk         (clk),
  .rst         (rst),
  .flush       (flush),
  .retireValid (retire.valid),
  .respValid   (retireResp.valid),
  .allocTaken  (allocTaken),
  .released    (released),
  .count       ('0)
);

bind ldqOccupancy ldqTop_sva #(
  .CheckResp  (1'b0),
  .CheckCount (1'b1)
) u_occSva (
  .clk         (clk),
  .rst         (rst),
  .flush       (flush),
  .retireValid (1'b0),
  .respValid   (1'b0),
  .allocTaken  (allocTaken),
  .released    (released),
  .count       (count)
);

/* ldqTop_tb.sv */
`timescale 1ns/1ps
`include "ldq_defines.svh"

module ldqTop_tb;

  localparam int ClkPeriod   = 8;
  localparam int ResetCycles = 4;
  localparam int Cols        = 15;
  localparam int MaxVectors  = 128;

  // column positions inside one vector record
  localparam int ColTest       = 0;
  localparam int ColFlush      = 1;
  localparam int ColAllocValid = 2;
  localparam int ColAllocAddr  = 3;
  localparam int ColAllocBanks = 4;
  localparam int ColAllocIi    = 5;
  localparam int ColChkValid   = 6;
  localparam int ColChkAddr    = 7;
  localparam int ColChkBanks   = 8;
  localparam int ColRetValid   = 9;
  localparam int ColRetIi      = 10;
  localparam int ColRespValid  = 11;
  localparam int ColRespHit    = 12;
  localparam int ColRespConfl  = 13;
  localparam int ColStall      = 14;

  logic                  clk;
  logic                  rst;
  logic                  flush;
  ldqMsgPkg::allocReqT   alloc;
  ldqMsgPkg::storeChkT   storeChk;
  ldqMsgPkg::retireReqT  retire;
  ldqMsgPkg::retireRespT retireResp;
  logic                  doStall;

  // unread words stay X, which marks the end of the vectors
  logic [`LDQ_ADDR_W-1:0] vecMem [0:MaxVectors*Cols-1];
  int                     numVectors;

  ldqTop u_ldqTop (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .alloc      (alloc),
    .storeChk   (storeChk),
    .retire     (retire),
    .retireResp (retireResp),
    .doStall    (doStall)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk = ~clk;
    end
  end

  function automatic logic [`LDQ_ADDR_W-1:0] vecField(input int k, input int col);
    return vecMem[k * Cols + col];
  endfunction

  function automatic int countVectors();
    int n;
    n = 0;
    while (n < MaxVectors && !$isunknown(vecField(n, ColTest))) begin
      n++;
    end
    return n;
  endfunction

  function automatic string testName(input int k);
    string label;
    case (int'(vecField(k, ColTest)))
      1: label = "alloc and retire";
      2: label = "store check match";
      3: label = "same-cycle corners";
      4: label = "retire unknown index";
      5: label = "occupancy stall";
      6: label = "flush";
      default: label = "unlabelled";
    endcase
    return $sformatf("%s, vector %0d", label, k);
  endfunction

  function automatic ldqMsgPkg::retireRespT expectedResp(input int k);
    ldqMsgPkg::retireRespT resp;
    resp.valid = (vecField(k, ColRespValid) != 0);
    resp.hit   = (vecField(k, ColRespHit) != 0);
    resp.confl = (vecField(k, ColRespConfl) != 0);
    return resp;
  endfunction

  task automatic idleInputs();
    flush    <= 1'b0;
    alloc    <= '0;
    storeChk <= '0;
    retire   <= '0;
  endtask

  task automatic applyVector(input int k);
    flush          <= (vecField(k, ColFlush) != 0);
    alloc.valid    <= (vecField(k, ColAllocValid) != 0);
    alloc.addr     <= ldqTypesPkg::lineAddrT'(vecField(k, ColAllocAddr));
    alloc.banks    <= ldqTypesPkg::bankMaskT'(vecField(k, ColAllocBanks));
    alloc.ii       <= ldqTypesPkg::instIdxT'(vecField(k, ColAllocIi));
    storeChk.valid <= (vecField(k, ColChkValid) != 0);
    storeChk.addr  <= ldqTypesPkg::lineAddrT'(vecField(k, ColChkAddr));
    storeChk.banks <= ldqTypesPkg::bankMaskT'(vecField(k, ColChkBanks));
    retire.valid   <= (vecField(k, ColRetValid) != 0);
    retire.ii      <= ldqTypesPkg::instIdxT'(vecField(k, ColRetIi));
  endtask

  task automatic checkRetire(input string name, input ldqMsgPkg::retireRespT expected,
                             input ldqMsgPkg::retireRespT actual);
    logic mismatch;
    mismatch = (expected.valid !== actual.valid);
    // hit and confl only mean something with valid
    if (expected.valid) begin
      mismatch = mismatch || (expected.hit !== actual.hit) ||
                 (expected.confl !== actual.confl);
    end
    if (mismatch) begin
      $display("[ERROR] %s: retireResp expected valid=%0b hit=%0b confl=%0b",
               name, expected.valid, expected.hit, expected.confl);
      $display("[ERROR] %s: retireResp actual valid=%0b hit=%0b confl=%0b",
               name, actual.valid, actual.hit, actual.confl);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic checkStall(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: doStall expected %0b, actual %0b", name, expected, actual);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // expectations of record k hold in the cycle after it was applied
  task automatic checkVector(input int k);
    checkRetire(testName(k), expectedResp(k), retireResp);
    checkStall(testName(k), vecField(k, ColStall) != 0, doStall);
  endtask

  task automatic runWatchdog(input int vectors);
    #((vectors + 20) * ClkPeriod);
    $display("watchdog expired before all vectors were applied and checked");
    $display("Testbench failed");
    $fatal(1);
  endtask

  initial begin
    rst <= 1'b1;
    idleInputs();
    $readmemh("ldq_vectors.txt", vecMem);
    numVectors = countVectors();
    if (numVectors == 0) begin
      $display("no vectors could be read from ldq_vectors.txt");
      $display("Testbench failed");
      $fatal(1);
    end
    fork
      runWatchdog(numVectors);
    join_none
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
    for (int k = 0; k < numVectors; k++) begin
      @(posedge clk);
      applyVector(k);
      @(negedge clk);
      if (k > 0) begin
        checkVector(k - 1);
      end
    end
    @(posedge clk);
    idleInputs();
    @(negedge clk);
    checkVector(numVectors - 1);
    $display("Testbench passed");
    $finish;
  end

endmodule

/* ldqTypesPkg.sv */
`include "ldq_defines.svh"

package ldqTypesPkg;

  // cache line address, byte offset already stripped
  typedef logic [`LDQ_ADDR_W-1:0] lineAddrT;

  // one bit per byte bank the access touches
  typedef logic [`LDQ_BANKS-1:0] bankMaskT;

  // instruction index, unique among valid loads
  typedef logic [`LDQ_II_W-1:0] instIdxT;

  // entry number inside the queue
  typedef logic [$clog2(`LDQ_ENTRIES)-1:0] entryIdxT;

  // valid entries, 0 up to full
  typedef logic [$clog2(`LDQ_ENTRIES+1)-1:0] occCountT;

endpackage

/* ldq_defines.svh */
`ifndef LDQ_DEFINES_SVH
`define LDQ_DEFINES_SVH

// queue depth
`define LDQ_ENTRIES 8

// field widths
`define LDQ_ADDR_W 36
`define LDQ_BANKS 32
`define LDQ_II_W 10

// occupancy at which the sender is asked to hold off
`define LDQ_STALL_LEVEL 6

`endif

/* ldq_vectors.txt */
// test flush | alloc: valid addr banks ii | store check: valid addr banks | retire: valid ii
// then expected one cycle later: resp valid, resp hit, resp confl, doStall
1 0 1 0000001A0 0000000F 001 0 000000000 00000000 0 000 0 0 0 0
1 0 0 000000000 00000000 000 0 000000000 00000000 1 001 1 1 0 0
1 0 0 000000000 00000000 000 0 000000000 00000000 0 000 0 0 0 0
2 0 1 0000001A0 000000F0 002 0 000000000 00000000 0 000 0 0 0 0
2 0 0 000000000 00000000 000 1 0000001A0 00000010 0 000 0 0 0 0
2 0 0 000000000 00000000 000 1 0000002B0 000000F0 0 000 0 0 0 0
2 0 0 000000000 00000000 000 0 000000000 00000000 1 002 1 1 1 0
2 0 1 0000001A0 0000FF00 003 0 000000000 00000000 0 000 0 0 0 0
2 0 0 000000000 00000000 000 1 0000001A0 000000FF 0 000 0 0 0 0
2 0 0 000000000 00000000 000 1 0000002B0 0000FF00 0 000 0 0 0 0
2 0 0 000000000 00000000 000 0 000000000 00000000 1 003 1 1 0 0
2 0 1 0000002B0 00000003 004 0 000000000 00000000 0 000 0 0 0 0
2 0 0 000000000 00000000 000 1 0000002B0 00000002 0 000 0 0 0 0
2 0 0 000000000 00000000 000 1 0000002B0 00000100 0 000 0 0 0 0
2 0 0 000000000 00000000 000 1 0000001A0 00000003 0 000 0 0 0 0
2 0 0 000000000 00000000 000 0 000000000 00000000 1 004 1 1 1 0
3 0 1 0000001A0 0000000C 005 1 0000001A0 00000004 0 000 0 0 0 0
3 0 1 0000001A0 00000030 006 0 000000000 00000000 0 000 0 0 0 0
3 0 0 000000000 00000000 000 1 0000001A0 00000010 1 006 1 1 1 0
3 0 0 000000000 00000000 000 0 000000000 00000000 1 005 1 1 1 0
3 0 1 0000001A0 00000001 007 1 0000001A0 00000002 0 000 0 0 0 0
3 0 0 000000000 00000000 000 0 000000000 00000000 1 007 1 1 0 0
4 0 0 000000000 00000000 000 0 000000000 00000000 1 3FF 1 0 0 0
4 0 0 000000000 00000000 000 0 000000000 00000000 1 007 1 0 0 0
4 0 0 000000000 00000000 000 0 000000000 00000000 0 000 0 0 0 0
5 0 1 0000002B0 00000001 010 0 000000000 00000000 0 000 0 0 0 0
5 0 1 0000002B0 00000002 011 0 000000000 00000000 0 000 0 0 0 0
5 0 1 0000002B0 00000004 012 0 000000000 00000000 0 000 0 0 0 0
5 0 1 0000002B0 00000008 013 0 000000000 00000000 0 000 0 0 0 0
5 0 1 0000002B0 00000010 014 0 000000000 00000000 0 000 0 0 0 0
5 0 1 0000002B0 00000020 015 0 000000000 00000000 0 000 0 0 0 1
5 0 0 000000000 00000000 000 1 0000002B0 0000000A 0 000 0 0 0 1
5 0 0 000000000 00000000 000 0 000000000 00000000 1 015 1 1 0 0
5 0 0 000000000 00000000 000 0 000000000 00000000 1 011 1 1 1 0
5 0 0 000000000 00000000 000 0 000000000 00000000 1 010 1 1 0 0
5 0 0 000000000 00000000 000 0 000000000 00000000 1 013 1 1 1 0
5 0 0 000000000 00000000 000 0 000000000 00000000 0 000 0 0 0 0
6 0 1 0000001A0 0000000F 020 0 000000000 00000000 0 000 0 0 0 0
6 0 1 0000001A0 000000F0 021 0 000000000 00000000 0 000 0 0 0 0
6 0 1 0000001A0 00000F00 022 0 000000000 00000000 0 000 0 0 0 0
6 0 1 0000001A0 0000F000 023 0 000000000 00000000 0 000 0 0 0 1
6 1 1 0000001A0 000F0000 024 0 000000000 00000000 1 012 0 0 0 0
6 0 0 000000000 00000000 000 0 000000000 00000000 1 020 1 0 0 0
6 0 0 000000000 00000000 000 0 000000000 00000000 1 014 1 0 0 0
6 0 0 000000000 00000000 000 0 000000000 00000000 1 024 1 0 0 0
6 0 1 0000001A0 00000001 030 0 000000000 00000000 0 000 0 0 0 0
6 0 0 000000000 00000000 000 1 0000001A0 00000001 0 000 0 0 0 0
6 0 0 000000000 00000000 000 0 000000000 00000000 1 030 1 1 1 0
6 0 0 000000000 00000000 000 0 000000000 00000000 0 000 0 0 0 0
